// File: verification/rvCoreTestdata.hex
// word 0: program length L, then L instruction words (byte address in comment)
// then store count K, then K lines of expected store: address data
00000021
00500013 // 00: addi x0,x0,5     x0 stays zero
00002023 // 04: sw   x0,0(x0)
00C00093 // 08: addi x1,x0,12
FFB00113 // 0c: addi x2,x0,-5
002081B3 // 10: add  x3,x1,x2    x2 from mem, x1 from wb
00302223 // 14: sw   x3,4(x0)    store data bypassed
40208233 // 18: sub  x4,x1,x2
0030F2B3 // 1c: and  x5,x1,x3
0030E333 // 20: or   x6,x1,x3
001123B3 // 24: slt  x7,x2,x1    negative operand
00402423 // 28: sw   x4,8(x0)
00502623 // 2c: sw   x5,12(x0)
00602823 // 30: sw   x6,16(x0)
00702A23 // 34: sw   x7,20(x0)
0F017413 // 38: andi x8,x2,0xf0
7010E493 // 3c: ori  x9,x1,0x701
FFC12513 // 40: slti x10,x2,-4
00802C23 // 44: sw   x8,24(x0)
00902E23 // 48: sw   x9,28(x0)
02A02023 // 4c: sw   x10,32(x0)
00402583 // 50: lw   x11,4(x0)   reads back 7
00158633 // 54: add  x12,x11,x1  load-use stall
02C02223 // 58: sw   x12,36(x0)
00108663 // 5c: beq  x1,x1,+12   taken
02102423 // 60: sw   x1,40(x0)   flushed
02102623 // 64: sw   x1,44(x0)   flushed
00208463 // 68: beq  x1,x2,+8    not taken
02202823 // 6c: sw   x2,48(x0)
00C006EF // 70: jal  x13,+12     link 0x74
02102A23 // 74: sw   x1,52(x0)   flushed
02102C23 // 78: sw   x1,56(x0)   flushed
02D02E23 // 7c: sw   x13,60(x0)
0000006F // 80: jal  x0,0        spin
0000000C
00000000 00000000 // x0
00000004 00000007 // add
00000008 00000011 // sub
0000000C 00000004 // and
00000010 0000000F // or
00000014 00000001 // slt
00000018 000000F0 // andi
0000001C 0000070D // ori
00000020 00000001 // slti
00000024 00000013 // lw + add
00000030 FFFFFFFB // after beq not taken
0000003C 00000074 // jal link

// File: build.f
hw/rvPkg.sv
hw/rvAlu.sv
hw/rvRegFile.sv
hw/rvHazard.sv
hw/rvControl.sv
hw/rvDatapath.sv
hw/rvCore.sv
verification/rvCoreTb.sv

// File: run.sh
#!/bin/sh
# compile and run the rv32i core testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module rvCoreTb -o rvCoreSim
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/rvCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Test passed" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: verification/rvCoreTb.sv
/*
 * testbench for the rv32i pipelined core
 * models the instruction and data memories, runs the hand-assembled
 * program from the test data file and checks every store against
 * the expected address/data sequence
 */
`default_nettype none
`timescale 1ns/10ps

module rvCoreTb;

   localparam int memWords   = 256;  // per memory, 1 KiB each
   localparam int timeoutCyc = 2000; // budget for all expected stores
   localparam int drainCyc   = 20;   // extra cycles to catch stray stores

   logic        clk;
   logic        reset;
   logic [31:0] pc, instr, dataAddr, writeData, readData;
   logic        memWrite;

   logic [31:0] testData [0:memWords-1]; // raw file image
   logic [31:0] instrMem [0:memWords-1];
   logic [31:0] dataMem  [0:memWords-1];
   logic [31:0] expAddr  [0:memWords-1];
   logic [31:0] expData  [0:memWords-1];
   int          progLen, storeTotal, storeCount, errorCount, cycles;

   rvCore UUT (
      .clk(clk), .reset(reset),
      .pc(pc), .instr(instr),
      .dataAddr(dataAddr), .writeData(writeData), .readData(readData),
      .memWrite(memWrite)
   );

   always #10 clk = ~clk; // 20 ns period

   // both memories answer within the cycle, outside 1 KiB reads zero
   assign instr    = (pc[31:10] == '0) ? instrMem[pc[9:2]] : 32'h0;
   assign readData = (dataAddr[31:10] == '0) ? dataMem[dataAddr[9:2]] : 32'h0;

   function automatic logic [7:0] memIndex(input int n);
      memIndex = n[7:0]; // word index into a 256-entry array
   endfunction

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("CHECK FAILED: %s is 0x%08h, expected 0x%08h at %0t",
                  name, actual, expected, $time);
         errorCount++;
      end
   endtask

   // word 0 is L, then L instructions, then K and K addr/data pairs
   task automatic loadTestData();
      int i;
      for (i = 0; i < memWords; i++) begin
         testData[memIndex(i)] = 32'h0;
         instrMem[memIndex(i)] = 32'h0;
         dataMem[memIndex(i)]  = 32'h0;
      end
      $readmemh("verification/rvCoreTestdata.hex", testData);
      progLen = testData[0];
      if (progLen < 1 || progLen > memWords - 2) begin
         $display("test data holds an invalid program length of %0d words", progLen);
         errorCount++;
         return;
      end
      for (i = 0; i < progLen; i++)
         instrMem[memIndex(i)] = testData[memIndex(i + 1)];
      storeTotal = testData[memIndex(progLen + 1)];
      if (storeTotal < 0 || progLen + 2 + 2 * storeTotal > memWords) begin
         $display("test data holds an invalid store count of %0d", storeTotal);
         errorCount++;
         storeTotal = 0;
         return;
      end
      for (i = 0; i < storeTotal; i++) begin
         expAddr[memIndex(i)] = testData[memIndex(progLen + 2 + 2 * i)];
         expData[memIndex(i)] = testData[memIndex(progLen + 3 + 2 * i)];
      end
   endtask

   // memory write and store check, DUT outputs still hold pre-edge values
   always @(posedge clk) begin
      if (reset) begin
         if (memWrite !== 1'b0) begin
            $display("memWrite is not low during reset at %0t", $time);
            errorCount++;
         end
         checkValue("pc", pc, 32'h0); // fetch starts at address zero
      end else if (memWrite === 1'b1) begin
         if (dataAddr[31:10] == '0)
            dataMem[dataAddr[9:2]] <= writeData;
         if (storeCount < storeTotal) begin
            checkValue("dataAddr", dataAddr, expAddr[memIndex(storeCount)]);
            checkValue("writeData", writeData, expData[memIndex(storeCount)]);
         end else begin
            $display("unexpected extra store of 0x%08h to 0x%08h at %0t",
                     writeData, dataAddr, $time);
            errorCount++;
         end
         storeCount++;
      end
   end

   initial begin
      clk        = 1'b0;
      reset      = 1'b1;
      errorCount = 0;
      storeCount = 0;
      storeTotal = 0;
      progLen    = 0;
      cycles     = 0;
      loadTestData();
      repeat (10) @(negedge clk);
      reset = 1'b0; // released on a falling edge
      while (storeCount < storeTotal && cycles < timeoutCyc) begin
         @(negedge clk);
         cycles++;
      end
      if (storeCount < storeTotal) begin
         $display("timeout after %0d cycles, only %0d of %0d stores arrived",
                  cycles, storeCount, storeTotal);
         errorCount++;
      end else begin
         repeat (drainCyc) @(negedge clk); // core spins on jal x0,0 here
      end
      $display("errors: %0d, stores seen: %0d of %0d expected",
               errorCount, storeCount, storeTotal);
      if (errorCount == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/rvCore.sv
/*
 * rv32i five stage pipelined core
 * joins controller, datapath and hazard unit;
 * instruction and data memories sit outside and answer within the cycle
 */
`default_nettype none
`timescale 1ns/10ps

module rvCore (
   input  wire logic                   clk,
   input  wire logic                   reset,
   output logic [rvPkg::xlen-1:0]      pc,        // fetch address
   input  wire logic [rvPkg::xlen-1:0] instr,     // word at pc
   output logic [rvPkg::xlen-1:0]      dataAddr,  // memory stage address
   output logic [rvPkg::xlen-1:0]      writeData, // sw data
   input  wire logic [rvPkg::xlen-1:0] readData,  // lw data
   output logic                        memWrite
);

   rvPkg::instrWord         instrD;
   rvPkg::immSel            immSrcD;
   rvPkg::aluOp             aluControlE;
   rvPkg::resultSel         resultSrcW;
   rvPkg::fwdSel            fwdAE, fwdBE;
   logic                    zeroE, aluSrcE, pcSrcE, loadE;
   logic                    regWriteM, regWriteW;
   logic                    stallF, stallD, flushD, flushE;
   logic [rvPkg::regAddrWidth-1:0] rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;

   rvControl control (
      .clk(clk), .reset(reset),
      .instrD(instrD), .zeroE(zeroE), .flushE(flushE),
      .immSrcD(immSrcD), .aluControlE(aluControlE), .aluSrcE(aluSrcE),
      .pcSrcE(pcSrcE), .loadE(loadE),
      .regWriteM(regWriteM), .memWriteM(memWrite),
      .regWriteW(regWriteW), .resultSrcW(resultSrcW)
   );

   rvDatapath datapath (
      .clk(clk), .reset(reset),
      .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
      .pcF(pc), .instrF(instr), .instrD(instrD),
      .immSrcD(immSrcD), .aluControlE(aluControlE), .aluSrcE(aluSrcE),
      .pcSrcE(pcSrcE), .zeroE(zeroE), .fwdAE(fwdAE), .fwdBE(fwdBE),
      .aluResultM(dataAddr), .writeDataM(writeData), .readDataM(readData),
      .regWriteW(regWriteW), .resultSrcW(resultSrcW),
      .rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E),
      .rdE(rdE), .rdM(rdM), .rdW(rdW)
   );

   rvHazard hazard (
      .rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E),
      .rdE(rdE), .rdM(rdM), .rdW(rdW),
      .loadE(loadE), .pcSrcE(pcSrcE),
      .regWriteM(regWriteM), .regWriteW(regWriteW),
      .fwdAE(fwdAE), .fwdBE(fwdBE),
      .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
   );

endmodule

`default_nettype wire

// File: hw/rvDatapath.sv
/*
 * pipeline datapath
 * pc and the four pipeline registers, register file, immediate
 * extension, operand bypass, ALU, branch target adder and the
 * writeback result mux
 */
`default_nettype none
`timescale 1ns/10ps

module rvDatapath (
   input  wire logic                      clk,
   input  wire logic                      reset,
   input  wire logic                      stallF,
   input  wire logic                      stallD,
   input  wire logic                      flushD,
   input  wire logic                      flushE,
   output logic [rvPkg::xlen-1:0]         pcF,
   input  wire logic [rvPkg::xlen-1:0]    instrF,
   output rvPkg::instrWord                instrD,
   input  wire rvPkg::immSel              immSrcD,
   input  wire rvPkg::aluOp               aluControlE,
   input  wire logic                      aluSrcE,
   input  wire logic                      pcSrcE,
   output logic                           zeroE,
   input  wire rvPkg::fwdSel              fwdAE,
   input  wire rvPkg::fwdSel              fwdBE,
   output logic [rvPkg::xlen-1:0]         aluResultM,
   output logic [rvPkg::xlen-1:0]         writeDataM,
   input  wire logic [rvPkg::xlen-1:0]    readDataM,
   input  wire logic                      regWriteW,
   input  wire rvPkg::resultSel           resultSrcW,
   output logic [rvPkg::regAddrWidth-1:0] rs1D, rs2D, rs1E, rs2E,
   output logic [rvPkg::regAddrWidth-1:0] rdE, rdM, rdW
);

   localparam int w = rvPkg::xlen;

   logic [w-1:0] pcPlus4F, pcNextF;
   logic [w-1:0] pcD, pcPlus4D, rd1D, rd2D, immExtD;
   logic [w-1:0] rd1E, rd2E, pcE, pcPlus4E, immExtE;
   logic [w-1:0] srcAE, srcBE, writeDataE, aluResultE, pcTargetE;
   logic [w-1:0] pcPlus4M;
   logic [w-1:0] aluResultW, readDataW, pcPlus4W, resultW;
   logic [rvPkg::regAddrWidth-1:0] rdD;

   // bypass mux for one execute operand
   function automatic logic [w-1:0] pickOperand(input rvPkg::fwdSel sel,
                                                input logic [w-1:0] regVal,
                                                input logic [w-1:0] wbVal,
                                                input logic [w-1:0] memVal);
      case (sel)
         rvPkg::fwdWriteback: pickOperand = wbVal;
         rvPkg::fwdMemory:    pickOperand = memVal;
         default:             pickOperand = regVal;
      endcase
   endfunction

   // fetch
   assign pcPlus4F = pcF + 32'd4;
   assign pcNextF  = pcSrcE ? pcTargetE : pcPlus4F; // taken branch or jal wins

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         pcF <= '0;
      else if (!stallF)
         pcF <= pcNextF;
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset || flushD) begin
         instrD   <= '0;              // all-zero word decodes as a bubble
         pcD      <= '0;
         pcPlus4D <= '0;
      end else if (!stallD) begin
         instrD   <= instrF;
         pcD      <= pcF;
         pcPlus4D <= pcPlus4F;
      end
   end

   // decode
   assign rs1D = instrD.r.rs1;
   assign rs2D = instrD.r.rs2;
   assign rdD  = instrD.r.rd;

   rvRegFile regFile (
      .clk(clk), .we(regWriteW),
      .ra1(rs1D), .ra2(rs2D), .wa(rdW), .wd(resultW),
      .rd1(rd1D), .rd2(rd2D)
   );

   always_comb begin
      case (immSrcD)
         rvPkg::immS: immExtD = {{20{instrD.s.immHi[6]}}, instrD.s.immHi, instrD.s.immLo};
         rvPkg::immB: immExtD = {{20{instrD.b.imm12}}, instrD.b.imm11, instrD.b.imm10to5,
                                 instrD.b.imm4to1, 1'b0};
         rvPkg::immJ: immExtD = {{12{instrD.j.imm20}}, instrD.j.imm19to12, instrD.j.imm11,
                                 instrD.j.imm10to1, 1'b0};
         default:     immExtD = {{20{instrD.i.imm[11]}}, instrD.i.imm};
      endcase
   end

   // execute
   always_ff @(posedge clk or posedge reset) begin
      if (reset || flushE) begin
         rd1E     <= '0;
         rd2E     <= '0;
         pcE      <= '0;
         pcPlus4E <= '0;
         immExtE  <= '0;
         rs1E     <= '0;
         rs2E     <= '0;
         rdE      <= '0;             // x0 so no bypass matches a bubble
      end else begin
         rd1E     <= rd1D;
         rd2E     <= rd2D;
         pcE      <= pcD;
         pcPlus4E <= pcPlus4D;
         immExtE  <= immExtD;
         rs1E     <= rs1D;
         rs2E     <= rs2D;
         rdE      <= rdD;
      end
   end

   assign srcAE      = pickOperand(fwdAE, rd1E, resultW, aluResultM);
   assign writeDataE = pickOperand(fwdBE, rd2E, resultW, aluResultM);
   assign srcBE      = aluSrcE ? immExtE : writeDataE;
   assign pcTargetE  = pcE + immExtE;

   rvAlu alu (
      .a(srcAE), .b(srcBE), .control(aluControlE),
      .result(aluResultE), .zero(zeroE)
   );

   // memory and writeback
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         aluResultM <= '0;
         writeDataM <= '0;
         pcPlus4M   <= '0;
         rdM        <= '0;
         aluResultW <= '0;
         readDataW  <= '0;
         pcPlus4W   <= '0;
         rdW        <= '0;
      end else begin
         aluResultM <= aluResultE;
         writeDataM <= writeDataE;
         pcPlus4M   <= pcPlus4E;
         rdM        <= rdE;
         aluResultW <= aluResultM;
         readDataW  <= readDataM;
         pcPlus4W   <= pcPlus4M;
         rdW        <= rdM;
      end
   end

   always_comb begin
      case (resultSrcW)
         rvPkg::resMem: resultW = readDataW;
         rvPkg::resPc4: resultW = pcPlus4W;   // jal link
         default:       resultW = aluResultW;
      endcase
   end

   // reset value, +4 steps and even immediates keep pc on words
   assert property (@(posedge clk) disable iff (reset) pcF[1:0] == 2'b00)
      else $error("fetch address 0x%08h not word aligned", pcF);

endmodule

`default_nettype wire

// File: hw/rvControl.sv
/*
 * pipeline controller
 * decodes the instruction in decode, carries its control bits
 * through execute, memory and writeback, and resolves beq and jal
 * in execute
 */
`default_nettype none
`timescale 1ns/10ps

module rvControl (
   input  wire logic            clk,
   input  wire logic            reset,
   input  wire rvPkg::instrWord instrD,
   input  wire logic            zeroE,
   input  wire logic            flushE,      // bubble into execute
   output rvPkg::immSel         immSrcD,
   output rvPkg::aluOp          aluControlE,
   output logic                 aluSrcE,     // 1 selects the immediate
   output logic                 pcSrcE,      // redirect fetch
   output logic                 loadE,       // for load-use detection
   output logic                 regWriteM,
   output logic                 memWriteM,
   output logic                 regWriteW,
   output rvPkg::resultSel      resultSrcW
);

   logic            regWriteD, memWriteD, branchD, jumpD, aluSrcD;
   logic            useFunct3D, forceSubD;
   rvPkg::resultSel resultSrcD, resultSrcE, resultSrcM;
   rvPkg::aluOp     aluControlD;
   logic            regWriteE, memWriteE, branchE, jumpE;

   // main decoder, unknown opcodes and the all-zero reset word do nothing
   always_comb begin
      regWriteD  = 1'b0;
      memWriteD  = 1'b0;
      branchD    = 1'b0;
      jumpD      = 1'b0;
      aluSrcD    = 1'b0;
      useFunct3D = 1'b0;
      forceSubD  = 1'b0;
      resultSrcD = rvPkg::resAlu;
      immSrcD    = rvPkg::immI;
      case (instrD.r.opcode)
         rvPkg::opLoad: begin
            regWriteD  = 1'b1;
            aluSrcD    = 1'b1;           // base + offset
            resultSrcD = rvPkg::resMem;
         end
         rvPkg::opStore: begin
            memWriteD = 1'b1;
            aluSrcD   = 1'b1;
            immSrcD   = rvPkg::immS;
         end
         rvPkg::opRtype: begin
            regWriteD  = 1'b1;
            useFunct3D = 1'b1;
         end
         rvPkg::opItype: begin
            regWriteD  = 1'b1;
            aluSrcD    = 1'b1;
            useFunct3D = 1'b1;
         end
         rvPkg::opBranch: begin
            branchD   = 1'b1;
            forceSubD = 1'b1;            // compare via zero flag
            immSrcD   = rvPkg::immB;
         end
         rvPkg::opJal: begin
            regWriteD  = 1'b1;
            jumpD      = 1'b1;
            resultSrcD = rvPkg::resPc4;  // link address
            immSrcD    = rvPkg::immJ;
         end
         default: ;
      endcase
   end

   // ALU decoder
   always_comb begin
      aluControlD = rvPkg::aluAdd;       // address arithmetic
      if (forceSubD)
         aluControlD = rvPkg::aluSub;
      else if (useFunct3D) begin
         case (instrD.r.funct3)
            rvPkg::funct3Add:
               if (instrD.r.funct7[5] && instrD.r.opcode == rvPkg::opRtype)
                  aluControlD = rvPkg::aluSub; // addi never subtracts
            rvPkg::funct3Slt: aluControlD = rvPkg::aluSlt;
            rvPkg::funct3Or:  aluControlD = rvPkg::aluOr;
            rvPkg::funct3And: aluControlD = rvPkg::aluAnd;
            default: ;
         endcase
      end
   end

   // execute stage control, cleared on a bubble
   always_ff @(posedge clk or posedge reset) begin
      if (reset || flushE) begin
         regWriteE   <= 1'b0;
         memWriteE   <= 1'b0;
         branchE     <= 1'b0;
         jumpE       <= 1'b0;
         aluSrcE     <= 1'b0;
         resultSrcE  <= rvPkg::resAlu;
         aluControlE <= rvPkg::aluAdd;
      end else begin
         regWriteE   <= regWriteD;
         memWriteE   <= memWriteD;
         branchE     <= branchD;
         jumpE       <= jumpD;
         aluSrcE     <= aluSrcD;
         resultSrcE  <= resultSrcD;
         aluControlE <= aluControlD;
      end
   end

   assign pcSrcE = (branchE & zeroE) | jumpE; // beq taken or jal
   assign loadE  = (resultSrcE == rvPkg::resMem);

   // memory and writeback stage control
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         regWriteM  <= 1'b0;
         memWriteM  <= 1'b0;
         resultSrcM <= rvPkg::resAlu;
         regWriteW  <= 1'b0;
         resultSrcW <= rvPkg::resAlu;
      end else begin
         regWriteM  <= regWriteE;
         memWriteM  <= memWriteE;
         resultSrcM <= resultSrcE;
         regWriteW  <= regWriteM;
         resultSrcW <= resultSrcM;
      end
   end

   // a store never also targets the register file
   assert property (@(posedge clk) disable iff (reset) !(memWriteE && regWriteE))
      else $error("execute stage raises memWrite and regWrite together");

endmodule

`default_nettype wire

// File: hw/rvHazard.sv
/*
 * hazard unit
 * bypass selects for execute, one-cycle load-use stall, and the
 * decode/execute flushes behind a taken branch or jal
 */
`default_nettype none
`timescale 1ns/10ps

module rvHazard (
   input  wire logic [rvPkg::regAddrWidth-1:0] rs1D, rs2D, rs1E, rs2E,
   input  wire logic [rvPkg::regAddrWidth-1:0] rdE, rdM, rdW,
   input  wire logic                           loadE,
   input  wire logic                           pcSrcE,
   input  wire logic                           regWriteM,
   input  wire logic                           regWriteW,
   output rvPkg::fwdSel                        fwdAE,
   output rvPkg::fwdSel                        fwdBE,
   output logic                                stallF,
   output logic                                stallD,
   output logic                                flushD,
   output logic                                flushE
);

   logic loadStall;

   // memory stage is younger, so it wins over writeback
   always_comb begin
      fwdAE = rvPkg::fwdNone;
      fwdBE = rvPkg::fwdNone;
      if (rs1E != '0) begin
         if (regWriteM && rs1E == rdM)
            fwdAE = rvPkg::fwdMemory;
         else if (regWriteW && rs1E == rdW)
            fwdAE = rvPkg::fwdWriteback;
      end
      if (rs2E != '0) begin
         if (regWriteM && rs2E == rdM)
            fwdBE = rvPkg::fwdMemory;
         else if (regWriteW && rs2E == rdW)
            fwdBE = rvPkg::fwdWriteback;
      end
   end

   // load data exists only after memory, hold the consumer one cycle
   assign loadStall = loadE && (rdE != '0) && (rdE == rs1D || rdE == rs2D);

   assign stallF = loadStall;
   assign stallD = loadStall;
   assign flushD = pcSrcE;                 // kill the two younger fetches
   assign flushE = loadStall | pcSrcE;     // bubble or kill

   // execute holds either a load or a branch/jal, never both
   always_comb begin
      assert (!(stallD && flushD))
         else $error("decode stalled and flushed in the same cycle");
   end

endmodule

`default_nettype wire

// File: hw/rvRegFile.sv
/*
 * integer register file
 * x1..x31 with two combinational reads, x0 reads as zero;
 * written on the falling edge so decode sees the writeback value
 */
`default_nettype none
`timescale 1ns/10ps

module rvRegFile (
   input  wire logic                           clk,
   input  wire logic                           we,
   input  wire logic [rvPkg::regAddrWidth-1:0] ra1,
   input  wire logic [rvPkg::regAddrWidth-1:0] ra2,
   input  wire logic [rvPkg::regAddrWidth-1:0] wa,
   input  wire logic [rvPkg::xlen-1:0]         wd,
   output logic [rvPkg::xlen-1:0]              rd1,
   output logic [rvPkg::xlen-1:0]              rd2
);

   logic [rvPkg::xlen-1:0] regs [1:31]; // no storage for x0

   always_ff @(negedge clk) begin
      if (we && wa != '0)
         regs[wa] <= wd;
   end

   assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// File: hw/rvAlu.sv
/*
 * execute stage ALU
 * add, sub, and, or and signed set-less-than, plus a zero flag
 * for beq
 */
`default_nettype none
`timescale 1ns/10ps

module rvAlu (
   input  wire logic [rvPkg::xlen-1:0] a,
   input  wire logic [rvPkg::xlen-1:0] b,
   input  wire rvPkg::aluOp            control,
   output logic [rvPkg::xlen-1:0]      result,
   output logic                        zero
);

   logic                   subtract;
   logic [rvPkg::xlen-1:0] condInvB, sum;
   logic                   overflow;

   // slt shares the subtractor
   assign subtract = (control == rvPkg::aluSub) || (control == rvPkg::aluSlt);
   assign condInvB = subtract ? ~b : b;
   assign sum      = a + condInvB + {{(rvPkg::xlen-1){1'b0}}, subtract};

   // same operand signs in, different sign out
   assign overflow = ~(a[rvPkg::xlen-1] ^ condInvB[rvPkg::xlen-1]) &
                     (a[rvPkg::xlen-1] ^ sum[rvPkg::xlen-1]);

   always_comb begin
      case (control)
         rvPkg::aluAnd: result = a & b;
         rvPkg::aluOr:  result = a | b;
         rvPkg::aluSlt: result = {{(rvPkg::xlen-1){1'b0}}, sum[rvPkg::xlen-1] ^ overflow};
         default:       result = sum;  // add, sub
      endcase
   end

   assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hw/rvPkg.sv
/*
 * rv32i pipeline shared definitions
 * widths, opcodes and funct3 codes of the supported subset,
 * ALU, immediate, result and forwarding select encodings,
 * and the instruction word with its R/I/S/B/J views
 */
`default_nettype none

package rvPkg;

   localparam int xlen         = 32; // data and address width
   localparam int regAddrWidth = 5;  // register index width

   // major opcodes of the supported instructions
   localparam logic [6:0] opLoad   = 7'b0000011; // lw
   localparam logic [6:0] opStore  = 7'b0100011; // sw
   localparam logic [6:0] opRtype  = 7'b0110011; // add sub and or slt
   localparam logic [6:0] opItype  = 7'b0010011; // addi andi ori slti
   localparam logic [6:0] opBranch = 7'b1100011; // beq
   localparam logic [6:0] opJal    = 7'b1101111;

   // funct3 of the ALU operations, shared by R and I forms
   localparam logic [2:0] funct3Add = 3'b000; // also sub, told apart by funct7[5]
   localparam logic [2:0] funct3Slt = 3'b010;
   localparam logic [2:0] funct3Or  = 3'b110;
   localparam logic [2:0] funct3And = 3'b111;

   typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp;

   typedef enum logic [1:0] {immI, immS, immB, immJ} immSel;

   // writeback source: ALU, load data or link address
   typedef enum logic [1:0] {resAlu, resMem, resPc4} resultSel;

   // operand bypass source in execute
   typedef enum logic [1:0] {fwdNone, fwdWriteback, fwdMemory} fwdSel;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rFormat;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } iFormat;

   typedef struct packed {
      logic [6:0] immHi; // offset[11:5]
      logic [4:0] rs2;   // store data
      logic [4:0] rs1;   // base
      logic [2:0] funct3;
      logic [4:0] immLo; // offset[4:0]
      logic [6:0] opcode;
   } sFormat;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10to5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4to1;
      logic       imm11;
      logic [6:0] opcode;
   } bFormat;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10to1;
      logic       imm11;
      logic [7:0] imm19to12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } jFormat;

   // one word, five decodings
   typedef union packed {
      rFormat r;
      iFormat i;
      sFormat s;
      bFormat b;
      jFormat j;
   } instrWord;

endpackage

`default_nettype wire
